/* build.f */
hdl/rv_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/operand_forward.sv
hdl/alu.sv
hdl/branch_resolve.sv
hdl/execute.sv
hdl/execute_stage.sv
sim/execute_props.sv
sim/tb_execute.sv

/* Makefile */
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_execute
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_execute.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_execute
    import rv_isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int N_ARITH      = 200;
    localparam int N_FORWARD    = 300;
    localparam int N_FLOW       = 200;
    localparam int N_SYSTEM     = 150;
    localparam int N_BUBBLE     = 200;
    localparam int TOTAL_CYCLES = 11 + N_ARITH + N_FORWARD + N_FLOW + N_SYSTEM + N_BUBBLE;

    logic        clk = 1'b0;
    logic        rst_n;
    id_ex_t      id_ex;
    reg_write_t  wb_forward;
    ex_mem_t     ex_mem;
    reg_write_t  ex_forward;
    logic [31:0] lfsr = 32'h1609_6b59;
    reg_write_t  model_mem_fwd;
    int          checks = 0;
    int          errors = 0;

    op_t arith_ops [23] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, ADDI, ANDI,
                            ORI, XORI, SLLI, SRLI, SRAI, SLTI, SLTIU, LUI, AUIPC, LD, SD};
    op_t flow_ops [8]   = '{BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR};
    op_t system_ops [9] = '{CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI, ECALL, EBREAK, MRET};

    execute_stage DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_ex      (id_ex),
        .wb_forward (wb_forward),
        .ex_mem     (ex_mem),
        .ex_forward (ex_forward)
    );

    always #(CLK_PERIOD / 2) clk = !clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random source from x^32 + x^22 + x^2 + x + 1
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic writes_reg(input op_t op);
        return op inside {[ADD:JALR], [CSRRW:CSRRCI]};
    endfunction

    function automatic logic is_csr(input op_t op);
        return op inside {[CSRRW:CSRRCI]};
    endfunction

    function automatic logic is_transfer(input op_t op);
        return op inside {[JAL:BGEU], ECALL, EBREAK, MRET};
    endfunction

    function automatic word_t pick_operand(input reg_addr_t addr, input word_t value,
                                           input reg_write_t mem, input reg_write_t wb);
        if (mem.write_enable && mem.dest_addr != '0 && mem.dest_addr == addr) begin
            return mem.write_data;
        end
        if (wb.write_enable && wb.dest_addr != '0 && wb.dest_addr == addr) begin
            return wb.write_data;
        end
        return value;
    endfunction

    function automatic ex_mem_t expect_bundle(input id_ex_t in, input reg_write_t mem,
                                              input reg_write_t wb);
        ex_mem_t e;
        word_t   a;
        word_t   b;
        word_t   rhs;
        word_t   src;
        word_t   res;
        word_t   tgt;
        word_t   csr_new;
        logic    taken;
        a   = pick_operand(in.reg1_addr, in.reg1_value, mem, wb);
        b   = pick_operand(in.reg2_addr, in.reg2_value, mem, wb);
        rhs = (in.op inside {[ADDI:SLTIU]}) ? in.immed : b;
        src = (in.op inside {CSRRWI, CSRRSI, CSRRCI}) ? {59'd0, in.reg1_addr} : a;
        res = '0;
        tgt = '0;
        csr_new = in.csr_value;
        taken = 1'b0;
        case (in.op)
            ADD, ADDI:   res = a + rhs;
            SUB:         res = a - rhs;
            AND, ANDI:   res = a & rhs;
            OR, ORI:     res = a | rhs;
            XOR, XORI:   res = a ^ rhs;
            SLL, SLLI:   res = a << rhs[5:0];
            SRL, SRLI:   res = a >> rhs[5:0];
            SRA, SRAI:   res = word_t'($signed(a) >>> rhs[5:0]);
            SLT, SLTI:   res = {63'd0, $signed(a) < $signed(rhs)};
            SLTU, SLTIU: res = {63'd0, a < rhs};
            LUI:         res = in.immed;
            AUIPC:       res = in.inst_pc + in.immed;
            JAL, JALR:   res = in.inst_pc + 64'd4;
            LD, SD:      res = a + in.immed;
            default:     res = is_csr(in.op) ? in.csr_value : '0;
        endcase
        case (in.op)
            JAL:           tgt = in.inst_pc + in.immed;
            JALR:          tgt = (a + in.immed) & ~64'd1;
            ECALL, EBREAK: tgt = in.mtvec;
            MRET:          tgt = in.mepc;
            default:       tgt = in.inst_pc + in.immed;
        endcase
        case (in.op)
            JAL, JALR, ECALL, EBREAK, MRET: taken = 1'b1;
            BEQ:     taken = (a == b);
            BNE:     taken = (a != b);
            BLT:     taken = $signed(a) < $signed(b);
            BGE:     taken = $signed(a) >= $signed(b);
            BLTU:    taken = a < b;
            BGEU:    taken = a >= b;
            default: taken = 1'b0;
        endcase
        case (in.op)
            CSRRW, CSRRWI: csr_new = src;
            CSRRS, CSRRSI: csr_new = in.csr_value | src;
            CSRRC, CSRRCI: csr_new = in.csr_value & ~src;
            default:       csr_new = in.csr_value;
        endcase
        e = '0;
        e.valid          = in.valid;
        e.inst           = in.inst;
        e.inst_pc        = in.inst_pc;
        e.op             = in.op;
        e.alu_result     = res;
        e.write_mem_data = b;
        e.inst_counter   = in.inst_counter;
        e.jump.do_jump      = in.valid && taken;
        e.jump.jump_inst    = is_transfer(in.op);
        e.jump.dest_addr    = tgt;
        e.jump.inst_counter = in.inst_counter;
        e.csr.write_enable = in.valid && is_csr(in.op);
        e.csr.dest_addr    = in.inst[31:20];
        e.csr.write_data   = csr_new;
        e.csr.pc           = in.inst_pc;
        e.csr.ecall        = (in.op == ECALL);
        e.csr.ebreak       = (in.op == EBREAK);
        e.csr.mret         = (in.op == MRET);
        e.csr.plain        = in.op inside {CSRRW, CSRRWI};
        e.reg_write.write_enable = in.valid && writes_reg(in.op);
        e.reg_write.dest_addr    = in.inst[11:7];
        e.reg_write.write_data   = res;
        return e;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_reset_state();
        check_value("ex_mem.valid", 128'(ex_mem.valid), '0);
        check_value("ex_mem.reg_write.write_enable", 128'(ex_mem.reg_write.write_enable), '0);
        check_value("ex_mem.csr.write_enable", 128'(ex_mem.csr.write_enable), '0);
        check_value("ex_mem.jump.do_jump", 128'(ex_mem.jump.do_jump), '0);
    endtask

    task automatic check_registered(input ex_mem_t e);
        check_value("ex_mem.valid", 128'(ex_mem.valid), 128'(e.valid));
        check_value("ex_mem.inst", 128'(ex_mem.inst), 128'(e.inst));
        check_value("ex_mem.inst_pc", 128'(ex_mem.inst_pc), 128'(e.inst_pc));
        check_value("ex_mem.op", 128'(ex_mem.op), 128'(e.op));
        check_value("ex_mem.inst_counter", 128'(ex_mem.inst_counter), 128'(e.inst_counter));
        if (writes_reg(e.op) || e.op inside {LD, SD}) begin
            check_value("ex_mem.alu_result", 128'(ex_mem.alu_result), 128'(e.alu_result));
        end
        check_value("ex_mem.write_mem_data", 128'(ex_mem.write_mem_data),
                    128'(e.write_mem_data));
        check_value("ex_mem.jump.do_jump", 128'(ex_mem.jump.do_jump), 128'(e.jump.do_jump));
        check_value("ex_mem.jump.jump_inst", 128'(ex_mem.jump.jump_inst),
                    128'(e.jump.jump_inst));
        if (is_transfer(e.op)) begin
            check_value("ex_mem.jump.dest_addr", 128'(ex_mem.jump.dest_addr),
                        128'(e.jump.dest_addr));
        end
        check_value("ex_mem.jump.inst_counter", 128'(ex_mem.jump.inst_counter),
                    128'(e.jump.inst_counter));
        check_value("ex_mem.csr.write_enable", 128'(ex_mem.csr.write_enable),
                    128'(e.csr.write_enable));
        check_value("ex_mem.csr.dest_addr", 128'(ex_mem.csr.dest_addr), 128'(e.csr.dest_addr));
        if (is_csr(e.op)) begin
            check_value("ex_mem.csr.write_data", 128'(ex_mem.csr.write_data),
                        128'(e.csr.write_data));
        end
        check_value("ex_mem.csr.pc", 128'(ex_mem.csr.pc), 128'(e.csr.pc));
        check_value("ex_mem.csr flags",
                    128'({ex_mem.csr.ecall, ex_mem.csr.ebreak, ex_mem.csr.mret, ex_mem.csr.plain}),
                    128'({e.csr.ecall, e.csr.ebreak, e.csr.mret, e.csr.plain}));
        check_value("ex_mem.reg_write.write_enable", 128'(ex_mem.reg_write.write_enable),
                    128'(e.reg_write.write_enable));
        check_value("ex_mem.reg_write.dest_addr", 128'(ex_mem.reg_write.dest_addr),
                    128'(e.reg_write.dest_addr));
        if (writes_reg(e.op)) begin
            check_value("ex_mem.reg_write.write_data", 128'(ex_mem.reg_write.write_data),
                        128'(e.reg_write.write_data));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hazard mode keeps addresses in x0..x3, otherwise sources x8..x15 and dest x16..x23
    task automatic make_bundle(input op_t op, input logic hazard, output id_ex_t b);
        b.valid        = 1'b1;
        b.inst         = 32'(rand_bits(32));
        b.inst_pc      = rand_bits(64) & ~64'd3;
        b.op           = op;
        b.reg1_value   = rand_bits(64);
        b.reg2_value   = rand_bits(64);
        b.immed        = rand_bits(64);
        b.csr_value    = rand_bits(64);
        b.mtvec        = rand_bits(64);
        b.mepc         = rand_bits(64);
        b.inst_counter = rand_bits(64);
        if (hazard) begin
            b.reg1_addr  = reg_addr_t'(rand_bits(2));
            b.reg2_addr  = reg_addr_t'(rand_bits(2));
            b.inst[11:7] = 5'(rand_bits(2));
        end else begin
            b.reg1_addr  = 5'd8 + 5'(rand_bits(3));
            b.reg2_addr  = 5'd8 + 5'(rand_bits(3));
            b.inst[11:7] = 5'd16 + 5'(rand_bits(3));
        end
        // equal operands now and then for the branch compares
        if (rand_bits(2) == 64'd0) begin
            b.reg2_addr  = b.reg1_addr;
            b.reg2_value = b.reg1_value;
        end
    endtask

    task automatic make_wb(input logic allow, output reg_write_t w);
        w.write_enable = allow && 1'(rand_bits(1));
        w.dest_addr    = reg_addr_t'(rand_bits(2));
        w.write_data   = rand_bits(64);
    endtask

    // entered a little after a rising edge and left at the same point one cycle later
    task automatic step(input id_ex_t in, input reg_write_t wb);
        ex_mem_t e;
        e = expect_bundle(in, model_mem_fwd, wb);
        id_ex      = in;
        wb_forward = wb;
        #5;
        check_value("ex_forward.write_enable", 128'(ex_forward.write_enable),
                    128'(e.reg_write.write_enable));
        check_value("ex_forward.dest_addr", 128'(ex_forward.dest_addr),
                    128'(e.reg_write.dest_addr));
        if (writes_reg(in.op)) begin
            check_value("ex_forward.write_data", 128'(ex_forward.write_data),
                        128'(e.reg_write.write_data));
        end
        @(posedge clk);
        #1;
        check_registered(e);
        model_mem_fwd = e.reg_write;
    endtask

    // kind 0 arith without hazards, 1 forwarding, 2 branches, 3 csr/system, 4 bubbles
    task automatic run_test(input string name, input int kind, input int count);
        id_ex_t     b;
        reg_write_t w;
        int         idx;
        int         n;
        int         checks_0;
        int         errors_0;
        checks_0 = checks;
        errors_0 = errors;
        for (n = 0; n < count; n++) begin
            case (kind)
                0: begin
                    idx = int'(rand_bits(8) % 64'd23);
                    make_bundle(arith_ops[idx], 1'b0, b);
                    make_wb(1'b0, w);
                end
                1: begin
                    idx = int'(rand_bits(8) % 64'd23);
                    make_bundle(arith_ops[idx], 1'b1, b);
                    make_wb(1'b1, w);
                end
                2: begin
                    idx = int'(rand_bits(3));
                    make_bundle(flow_ops[idx], 1'b1, b);
                    make_wb(1'b1, w);
                end
                3: begin
                    idx = int'(rand_bits(8) % 64'd9);
                    make_bundle(system_ops[idx], 1'b1, b);
                    make_wb(1'b1, w);
                end
                default: begin
                    make_bundle(op_t'(6'(rand_bits(8) % 64'd41)), 1'b1, b);
                    b.valid = 1'(rand_bits(1));
                    make_wb(1'b1, w);
                end
            endcase
            step(b, w);
        end
        $display("test %s: %0d checks, %0d errors", name, checks - checks_0, errors - errors_0);
    endtask

    initial begin
        rst_n = 1'b0;
        // reset has to win over a valid instruction
        make_bundle(ADD, 1'b1, id_ex);
        make_wb(1'b1, wb_forward);
        model_mem_fwd = '0;
        repeat (10) begin
            @(posedge clk);
            #1;
            check_reset_state();
        end
        rst_n      = 1'b1;
        // first edge out of reset carries the same writing op as a bubble
        id_ex.valid = 1'b0;
        wb_forward = '0;
        @(posedge clk);
        #1;
        check_reset_state();
        $display("test reset: %0d checks, %0d errors", checks, errors);

        run_test("arithmetic", 0, N_ARITH);
        run_test("forwarding", 1, N_FORWARD);
        run_test("branches and jumps", 2, N_FLOW);
        run_test("csr and system", 3, N_SYSTEM);
        run_test("bubbles", 4, N_BUBBLE);

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((TOTAL_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/execute_props.sv */
`default_nettype none
`timescale 1ns/100ps

module execute_props
    import pipe_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input id_ex_t     id_ex,
    input reg_write_t mem_forward,
    input reg_write_t wb_forward,
    input ex_mem_t    ex_mem_next,
    input ex_mem_t    ex_mem
);

    // register comes out of a reset cycle empty
    assert property (@(posedge clk) !rst_n |=> !ex_mem.valid)
        else $error("ex_mem.valid high after a reset cycle");

    assert property (@(posedge clk) disable iff (!rst_n)
        ex_mem.jump.do_jump |-> ex_mem.jump.jump_inst)
        else $error("do_jump set on a non control-transfer instruction");

    // requests to x0 leave operand 2 untouched
    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_forward.dest_addr == '0 && wb_forward.dest_addr == '0)
        |-> ex_mem_next.write_mem_data == id_ex.reg2_value)
        else $error("x0 write request changed operand 2");

endmodule

bind execute_stage execute_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .id_ex       (id_ex),
    .mem_forward (mem_forward),
    .wb_forward  (wb_forward),
    .ex_mem_next (ex_mem_next),
    .ex_mem      (ex_mem)
);

`default_nettype wire

/* hdl/execute_stage.sv */
`default_nettype none
`timescale 1ns/100ps

module execute_stage
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  id_ex_t     id_ex,
    input  reg_write_t wb_forward,
    output ex_mem_t    ex_mem,
    output reg_write_t ex_forward
);

    ex_mem_t    ex_mem_next;
    ex_mem_t    ex_mem_d;
    reg_write_t mem_forward;

    execute u_execute (
        .id_ex       (id_ex),
        .mem_forward (mem_forward),
        .wb_forward  (wb_forward),
        .ex_mem_next (ex_mem_next),
        .ex_forward  (ex_forward)
    );

    // a bubble keeps its payload but may not write or redirect
    always_comb begin
        ex_mem_d = ex_mem_next;
        if (!ex_mem_next.valid) begin
            ex_mem_d.reg_write.write_enable = 1'b0;
            ex_mem_d.csr.write_enable       = 1'b0;
            ex_mem_d.jump.do_jump           = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid                  <= 1'b0;
            ex_mem.reg_write.write_enable <= 1'b0;
            ex_mem.csr.write_enable       <= 1'b0;
            ex_mem.jump.do_jump           <= 1'b0;
        end else begin
            ex_mem <= ex_mem_d;
        end
    end

    // memory-stage bypass straight from the pipeline register
    always_comb begin
        mem_forward              = ex_mem.reg_write;
        mem_forward.write_enable = ex_mem.valid && ex_mem.reg_write.write_enable;
    end

endmodule

`default_nettype wire

/* hdl/execute.sv */
`default_nettype none
`timescale 1ns/100ps

module execute
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  id_ex_t     id_ex,
    input  reg_write_t mem_forward,
    input  reg_write_t wb_forward,
    output ex_mem_t    ex_mem_next,
    output reg_write_t ex_forward
);

    word_t op1;
    word_t op2;
    word_t alu_op1;
    word_t alu_result;
    word_t target;
    word_t new_csr;
    logic  do_jump;
    logic  jump_inst;
    logic  writes_reg;
    logic  is_csr;
    logic  is_csr_immed;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // op classes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        writes_reg   = 1'b0;
        is_csr       = 1'b0;
        is_csr_immed = 1'b0;
        case (id_ex.op)
            ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
            ADDI, ANDI, ORI, XORI, SLLI, SRLI, SRAI, SLTI, SLTIU,
            LUI, AUIPC, JAL, JALR: begin
                writes_reg = 1'b1;
            end
            CSRRW, CSRRS, CSRRC: begin
                writes_reg = 1'b1;
                is_csr     = 1'b1;
            end
            CSRRWI, CSRRSI, CSRRCI: begin
                writes_reg   = 1'b1;
                is_csr       = 1'b1;
                is_csr_immed = 1'b1;
            end
            default: ;
        endcase
    end

    operand_forward u_fwd_rs1 (
        .reg_addr    (id_ex.reg1_addr),
        .reg_value   (id_ex.reg1_value),
        .mem_forward (mem_forward),
        .wb_forward  (wb_forward),
        .operand     (op1)
    );

    operand_forward u_fwd_rs2 (
        .reg_addr    (id_ex.reg2_addr),
        .reg_value   (id_ex.reg2_value),
        .mem_forward (mem_forward),
        .wb_forward  (wb_forward),
        .operand     (op2)
    );

    // csr*i carries its zimm in the rs1 field
    assign alu_op1 = is_csr_immed ? {59'd0, id_ex.reg1_addr} : op1;

    alu u_alu (
        .op        (id_ex.op),
        .op1       (alu_op1),
        .op2       (op2),
        .immed     (id_ex.immed),
        .pc        (id_ex.inst_pc),
        .csr_value (id_ex.csr_value),
        .mtvec     (id_ex.mtvec),
        .mepc      (id_ex.mepc),
        .result    (alu_result),
        .target    (target),
        .new_csr   (new_csr)
    );

    branch_resolve u_branch (
        .op        (id_ex.op),
        .op1       (op1),
        .op2       (op2),
        .do_jump   (do_jump),
        .jump_inst (jump_inst)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output bundle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        ex_mem_next.valid          = id_ex.valid;
        ex_mem_next.inst           = id_ex.inst;
        ex_mem_next.inst_pc        = id_ex.inst_pc;
        ex_mem_next.op             = id_ex.op;
        ex_mem_next.alu_result     = alu_result;
        // store data must see the bypass too
        ex_mem_next.write_mem_data = op2;
        ex_mem_next.inst_counter   = id_ex.inst_counter;

        ex_mem_next.jump.do_jump      = do_jump;
        ex_mem_next.jump.jump_inst    = jump_inst;
        ex_mem_next.jump.dest_addr    = target;
        ex_mem_next.jump.inst_counter = id_ex.inst_counter;

        ex_mem_next.csr.write_enable = is_csr;
        ex_mem_next.csr.dest_addr    = id_ex.inst[31:20];
        ex_mem_next.csr.write_data   = new_csr;
        ex_mem_next.csr.pc           = id_ex.inst_pc;
        ex_mem_next.csr.ecall        = (id_ex.op == ECALL);
        ex_mem_next.csr.ebreak       = (id_ex.op == EBREAK);
        ex_mem_next.csr.mret         = (id_ex.op == MRET);
        ex_mem_next.csr.plain        = (id_ex.op == CSRRW) || (id_ex.op == CSRRWI);

        ex_mem_next.reg_write.write_enable = writes_reg;
        ex_mem_next.reg_write.dest_addr    = id_ex.inst[11:7];
        ex_mem_next.reg_write.write_data   = alu_result;
    end

    // bubbles forward nothing
    always_comb begin
        ex_forward              = ex_mem_next.reg_write;
        ex_forward.write_enable = id_ex.valid && writes_reg;
    end

endmodule

`default_nettype wire

/* hdl/branch_resolve.sv */
`default_nettype none
`timescale 1ns/100ps

module branch_resolve
    import rv_isa_pkg::*;
(
    input  op_t   op,
    input  word_t op1,
    input  word_t op2,
    output logic  do_jump,
    output logic  jump_inst
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (op1 == op2);
    assign lt_s = ($signed(op1) < $signed(op2));
    assign lt_u = (op1 < op2);

    // any control transfer, taken or not
    always_comb begin
        case (op)
            JAL, JALR, BEQ, BNE, BLT, BGE, BLTU, BGEU, ECALL, EBREAK, MRET: begin
                jump_inst = 1'b1;
            end
            default: begin
                jump_inst = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (op)
            JAL, JALR, ECALL, EBREAK, MRET: do_jump = 1'b1;
            BEQ:                            do_jump = eq;
            BNE:                            do_jump = !eq;
            BLT:                            do_jump = lt_s;
            BGE:                            do_jump = !lt_s;
            BLTU:                           do_jump = lt_u;
            BGEU:                           do_jump = !lt_u;
            default:                        do_jump = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/alu.sv */
`default_nettype none
`timescale 1ns/100ps

module alu
    import rv_isa_pkg::*;
(
    input  op_t   op,
    input  word_t op1,
    input  word_t op2,
    input  word_t immed,
    input  word_t pc,
    input  word_t csr_value,
    input  word_t mtvec,
    input  word_t mepc,
    output word_t result,
    output word_t target,
    output word_t new_csr
);

    word_t      rhs;
    logic [5:0] shamt;
    word_t      pc_next;
    word_t      addr_sum;

    // immediate forms take the second operand from immed
    always_comb begin
        case (op)
            ADDI, ANDI, ORI, XORI, SLLI, SRLI, SRAI, SLTI, SLTIU: begin
                rhs = immed;
            end
            default: begin
                rhs = op2;
            end
        endcase
    end

    assign shamt    = rhs[5:0];
    assign pc_next  = pc + 64'd4;
    assign addr_sum = op1 + immed;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (op)
            ADD, ADDI:   result = op1 + rhs;
            SUB:         result = op1 - rhs;
            AND, ANDI:   result = op1 & rhs;
            OR, ORI:     result = op1 | rhs;
            XOR, XORI:   result = op1 ^ rhs;
            SLL, SLLI:   result = op1 << shamt;
            SRL, SRLI:   result = op1 >> shamt;
            SRA, SRAI:   result = word_t'($signed(op1) >>> shamt);
            SLT, SLTI:   result = {63'd0, $signed(op1) < $signed(rhs)};
            SLTU, SLTIU: result = {63'd0, op1 < rhs};
            LUI:         result = immed;
            AUIPC:       result = pc + immed;
            // link address
            JAL, JALR:   result = pc_next;
            // rd gets the old csr
            CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI: begin
                result = csr_value;
            end
            LD, SD:      result = addr_sum;
            default:     result = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // redirect target
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (op)
            JAL, BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                target = pc + immed;
            end
            JALR: begin
                target = {addr_sum[63:1], 1'b0};
            end
            // trap entry
            ECALL, EBREAK: begin
                target = mtvec;
            end
            MRET: begin
                target = mepc;
            end
            // fall-through
            default: begin
                target = pc_next;
            end
        endcase
    end

    // csr update value
    always_comb begin
        case (op)
            CSRRW, CSRRWI: new_csr = op1;
            CSRRS, CSRRSI: new_csr = csr_value | op1;
            CSRRC, CSRRCI: new_csr = csr_value & ~op1;
            default:       new_csr = csr_value;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/operand_forward.sv */
`default_nettype none
`timescale 1ns/100ps

module operand_forward
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  reg_addr_t  reg_addr,
    input  word_t      reg_value,
    input  reg_write_t mem_forward,
    input  reg_write_t wb_forward,
    output word_t      operand
);

    logic mem_hit;
    logic wb_hit;

    // x0 is hardwired, never bypass it
    assign mem_hit = mem_forward.write_enable
                     && (mem_forward.dest_addr != '0)
                     && (mem_forward.dest_addr == reg_addr);

    assign wb_hit = wb_forward.write_enable
                    && (wb_forward.dest_addr != '0)
                    && (wb_forward.dest_addr == reg_addr);

    // younger result wins
    always_comb begin
        if (mem_hit) begin
            operand = mem_forward.write_data;
        end else if (wb_hit) begin
            operand = wb_forward.write_data;
        end else begin
            operand = reg_value;
        end
    end

endmodule

`default_nettype wire

/* hdl/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    import rv_isa_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode to execute
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        word_t       inst_pc;
        op_t         op;
        reg_addr_t   reg1_addr;
        reg_addr_t   reg2_addr;
        word_t       reg1_value;
        word_t       reg2_value;
        word_t       immed;
        // csr file snapshot
        word_t       csr_value;
        word_t       mtvec;
        word_t       mepc;
        // retire tag
        word_t       inst_counter;
    } id_ex_t;

    // register write, also used as a bypass
    typedef struct packed {
        logic      write_enable;
        reg_addr_t dest_addr;
        word_t     write_data;
    } reg_write_t;

    typedef struct packed {
        logic  do_jump;
        logic  jump_inst;
        word_t dest_addr;
        word_t inst_counter;
    } jump_t;

    typedef struct packed {
        logic      write_enable;
        csr_addr_t dest_addr;
        word_t     write_data;
        word_t     pc;
        logic      ecall;
        logic      ebreak;
        logic      mret;
        // csrrw / csrrwi
        logic      plain;
    } csr_write_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // execute to memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        word_t       inst_pc;
        op_t         op;
        word_t       alu_result;
        word_t       write_mem_data;
        word_t       inst_counter;
        jump_t       jump;
        csr_write_t  csr;
        reg_write_t  reg_write;
    } ex_mem_t;

endpackage

`default_nettype wire

/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    typedef logic [63:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decoded operations, as handed over by decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [5:0] {
        NOP,
        // register-register
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        // register-immediate
        ADDI,
        ANDI,
        ORI,
        XORI,
        SLLI,
        SRLI,
        SRAI,
        SLTI,
        SLTIU,
        // upper immediate, immed already shifted by decode
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        // only the address is formed here
        LD,
        SD,
        CSRRW,
        CSRRS,
        CSRRC,
        CSRRWI,
        CSRRSI,
        CSRRCI,
        ECALL,
        EBREAK,
        MRET
    } op_t;

endpackage

`default_nettype wire
